// File: Makefile
# Verilator build of the decode stage testbench

TOP = tbDecodeStage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f compile.f -Mdir obj_dir

# The simulator status is ignored here, the log search decides pass or fail
run: compile
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	@cat run.log
	@grep -q "^Test OK$$" run.log

clean:
	rm -rf obj_dir run.log

// File: compile.f
+incdir+tb
design/thorPkg.sv
design/fpCvt32To64.sv
design/insQueue.sv
design/immDecode.sv
design/decodeStage.sv
tb/tbDecodeStage.sv

// File: design/decodeStage.sv
/*
 * Decode stage slice for immediates: the instruction queue feeding the
 * immediate decoder, with push and ready as the only flow control
 */

module decodeStage import thorPkg::*; #(
	parameter int queueDepth = 8
) (
	input  logic clk,
	input  logic rstN,
	input  logic push,
	input  instruction_t insIn,
	output logic full,
	input  logic outReady,
	output logic outValid,
	output opcode_t outOpcode,
	output logic [63:0] imm,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic [2:0] outLen
);

	localparam int cntW = $clog2(queueDepth+1);

	// Queue to decoder
	instruction_t [windowSize-1:0] window;
	logic [cntW-1:0] availCount;
	// Decoder back to queue
	logic advance;
	logic [2:0] advanceCount;

	insQueue #(
		.depth(queueDepth)
	) insQueue_i (
		.clk(clk),
		.rstN(rstN),
		.push(push),
		.insIn(insIn),
		.advance(advance),
		.advanceCount(advanceCount),
		.window(window),
		.availCount(availCount),
		.full(full)
	);

	immDecode #(
		.depth(queueDepth)
	) immDecode_i (
		.clk(clk),
		.rstN(rstN),
		.window(window),
		.availCount(availCount),
		.outReady(outReady),
		.advance(advance),
		.advanceCount(advanceCount),
		.outValid(outValid),
		.outOpcode(outOpcode),
		.imm(imm),
		.imma(imma),
		.immb(immb),
		.immc(immc),
		.outLen(outLen)
	);

endmodule

// File: design/fpCvt32To64.sv
/*
 * Single to double precision widening, purely combinational.
 * Zero, infinity and NaN keep their class, denormals become signed zero
 */

module fpCvt32To64 (
	input  logic [31:0] single,
	output logic [63:0] double
);

	// ==============================
	// Field split
	// ==============================

	logic sign;
	logic [7:0] expIn;
	logic [22:0] manIn;
	logic [10:0] expOut;
	logic [51:0] manOut;

	assign sign = single[31];
	assign expIn = single[30:23];
	assign manIn = single[22:0];

	// The mantissa is simply padded on the right
	assign manOut = {manIn, 29'd0};

	// ==============================
	// Exponent rebias
	// ==============================

	always_comb begin
		if (expIn == 8'd0) begin
			// Zero and denormal inputs both land on zero
			expOut = 11'd0;
		end else if (expIn == 8'hFF) begin
			// Infinity or NaN, the mantissa decides which
			expOut = 11'h7FF;
		end else begin
			// Bias moves from 127 to 1023
			expOut = {3'd0, expIn} + 11'd896;
		end
	end

	always_comb begin
		if (expIn == 8'd0) begin
			// Flush keeps the sign so -0 stays -0
			double = {sign, 63'd0};
		end else begin
			double = {sign, expOut, manOut};
		end
	end

endmodule

// File: design/immDecode.sv
/*
 * Immediate decoder. Finds a base instruction and its prefix run in the
 * window, builds the base and A/B/C immediates and registers the result
 * with a valid level that holds under back-pressure
 */

module immDecode import thorPkg::*; #(
	parameter int depth = 8
) (
	input  logic clk,
	input  logic rstN,
	input  instruction_t [windowSize-1:0] window,
	input  logic [$clog2(depth+1)-1:0] availCount,
	input  logic outReady,
	output logic advance,
	output logic [2:0] advanceCount,
	output logic outValid,
	output opcode_t outOpcode,
	output logic [63:0] imm,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic [2:0] outLen
);

	localparam int cntW = $clog2(depth+1);
	localparam int numKinds = 4;
	// Prefix kinds in the only order they may follow a base
	localparam opcode_t pfxKind [numKinds] = '{OP_PFX, OP_PFXA, OP_PFXB, OP_PFXC};

	logic [1:0] nPfx [numKinds];
	logic [63:0] rawVal [numKinds];
	logic [63:0] cvtVal [numKinds];
	logic [63:0] baseImm;
	logic [63:0] immNext;
	logic [63:0] immaNext;
	logic [63:0] immbNext;
	logic [63:0] immcNext;
	logic [2:0] grpLen;
	logic pfxBase;
	logic flt;
	logic complete;
	logic fire;

	// Window read that treats anything past the fifth slot as a NOP
	function automatic instruction_t insAt(input instruction_t [windowSize-1:0] w, input int i);
		if (i < windowSize)
			return w[i];
		return nopIns;
	endfunction

	// A stray prefix in the base slot stands alone with zero immediates
	assign pfxBase = window[0].opcode inside {OP_PFX, OP_PFXA, OP_PFXB, OP_PFXC};
	assign flt = window[0].opcode inside {OP_FLT2, OP_FLT3};

	// ==============================
	// Group walk
	// ==============================

	always_comb begin : walkGroup
		int ndx;
		instruction_t first;
		instruction_t second;
		ndx = 1;
		for (int k = 0; k < numKinds; k++) begin
			nPfx[k] = 2'd0;
			rawVal[k] = 64'd0;
			first = insAt(window, ndx);
			second = insAt(window, ndx + 1);
			if (!pfxBase && first.opcode == pfxKind[k]) begin
				nPfx[k] = 2'd1;
				ndx = ndx + 1;
				// PFX carries 32 bits, the operand prefixes carry 33
				if (k == 0)
					rawVal[k] = {{32{first[pfxHi]}}, first[pfxHi:pfxLo]};
				else
					rawVal[k] = {{31{first[pfxHi]}}, first[pfxHi:pfxabcLo]};
				// A repeat of the same kind fills in the upper bits
				if (second.opcode == pfxKind[k]) begin
					nPfx[k] = 2'd2;
					ndx = ndx + 1;
					if (k == 0)
						rawVal[k][63:32] = second[pfxHi:pfxLo];
					else
						rawVal[k][63:33] = second[pfxExtHi:pfxabcLo];
				end
			end
		end
		grpLen = 3'(ndx);
	end

	// One widening per kind, fed from the low word of the integer value
	for (genvar k = 0; k < numKinds; k++) begin : cvt_g
		fpCvt32To64 cvt_i (
			.single(rawVal[k][31:0]),
			.double(cvtVal[k])
		);
	end

	// ==============================
	// Immediate build
	// ==============================

	always_comb begin : baseField
		case (window[0].opcode)
		OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI, OP_JSR,
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_CACHE,
		OP_STB, OP_STW, OP_STT, OP_STO:
			baseImm = {{48{window[0][immHi]}}, window[0][immHi:immLo]};
		OP_ANDI:
			baseImm = {48'hFFFF_FFFF_FFFF, window[0][immHi:immLo]};
		OP_ORI, OP_EORI:
			baseImm = {48'd0, window[0][immHi:immLo]};
		OP_CSR:
			baseImm = {50'd0, window[0][csrImmHi:immLo]};
		// Sign extends to 32 bits only
		OP_RTD:
			baseImm = {32'd0, {16{window[0][immHi]}}, window[0][immHi:immLo]};
		OP_FENCE:
			baseImm = {48'd0, window[0][fenceImmHi:fenceImmLo]};
		default:
			baseImm = 64'd0;
		endcase
	end

	// A lone prefix of a kind means single precision on FP opcodes
	always_comb begin : pickFinal
		immNext = baseImm;
		if (nPfx[0] != 2'd0)
			immNext = (flt && nPfx[0] == 2'd1) ? cvtVal[0] : rawVal[0];
		immaNext = (flt && nPfx[1] == 2'd1) ? cvtVal[1] : rawVal[1];
		immbNext = (flt && nPfx[2] == 2'd1) ? cvtVal[2] : rawVal[2];
		immcNext = (flt && nPfx[3] == 2'd1) ? cvtVal[3] : rawVal[3];
	end

	// ==============================
	// Handshake and output register
	// ==============================

	// Complete once the window is full or the next entry is visibly not a prefix
	assign complete = (grpLen == 3'd5) || (availCount > cntW'(grpLen));
	assign fire = complete && (!outValid || outReady);
	assign advance = fire;
	assign advanceCount = grpLen;

	always_ff @(posedge clk) begin
		if (!rstN)
			outValid <= 1'b0;
		else if (fire)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			outOpcode <= window[0].opcode;
			imm <= immNext;
			imma <= immaNext;
			immb <= immbNext;
			immc <= immcNext;
			outLen <= grpLen;
		end
	end

	// A stalled result must survive until the consumer takes it
	holdUnderBackpressure: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outOpcode) && $stable(imm)
			&& $stable(imma) && $stable(immb) && $stable(immc) && $stable(outLen)));

endmodule

// File: design/insQueue.sv
/*
 * Circular instruction queue. One push per strobe, a window of the five
 * oldest entries for the decoder, and an advance that pops several at once
 */

module insQueue import thorPkg::*; #(
	parameter int depth = 8
) (
	input  logic clk,
	input  logic rstN,
	input  logic push,
	input  instruction_t insIn,
	input  logic advance,
	input  logic [2:0] advanceCount,
	output instruction_t [windowSize-1:0] window,
	output logic [$clog2(depth+1)-1:0] availCount,
	output logic full
);

	localparam int cntW = $clog2(depth+1);
	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

	instruction_t mem [depth];
	logic [ptrW-1:0] rdPtr;
	logic [ptrW-1:0] wrPtr;
	logic [cntW-1:0] count;
	logic doPush;

	// Pointer step with wrap, n never exceeds the window size
	function automatic logic [ptrW-1:0] wrapPtr(input logic [ptrW-1:0] p, input logic [2:0] n);
		int sum;
		sum = int'(p) + int'(n);
		if (sum >= depth)
			sum = sum - depth;
		return ptrW'(sum);
	endfunction

	assign full = (count == cntW'(depth));
	assign availCount = count;
	// A push into a full queue is dropped here and flagged below
	assign doPush = push && !full;

	// ==============================
	// Storage
	// ==============================

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= insIn;
	end

	// Pointers and count, push and advance can land in the same cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrapPtr(wrPtr, 3'd1);
			if (advance)
				rdPtr <= wrapPtr(rdPtr, advanceCount);
			count <= count + cntW'(doPush) - (advance ? cntW'(advanceCount) : cntW'(0));
		end
	end

	// ==============================
	// Decoder window
	// ==============================

	// Slots past the fill level read as NOP so they never look like a prefix
	always_comb begin
		for (int i = 0; i < windowSize; i++) begin
			if (i < int'(count))
				window[i] = mem[wrapPtr(rdPtr, 3'(i))];
			else
				window[i] = nopIns;
		end
	end

	// The writer upstream has to watch full
	noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		!(push && full));

	// The decoder may only consume entries it could see
	noOverAdvance: assert property (@(posedge clk) disable iff (!rstN)
		advance |-> (cntW'(advanceCount) <= availCount));

endmodule

// File: design/thorPkg.sv
/*
 * Shared definitions for the decode stage: instruction width, opcode
 * encodings, the packed instruction layout and immediate field positions
 */

package thorPkg;

	// ==============================
	// Sizes
	// ==============================

	localparam int insWidth = 40;
	localparam int opcodeWidth = 7;

	// Number of queue entries the immediate decoder can look at
	localparam int windowSize = 5;

	// ==============================
	// Opcodes
	// ==============================

	typedef enum logic [opcodeWidth-1:0] {
		// Arithmetic with a 16-bit immediate
		OP_ADDI  = 7'd4,
		OP_SUBFI = 7'd5,
		OP_MULI  = 7'd6,
		OP_CMPI  = 7'd11,
		OP_DIVI  = 7'd13,
		OP_SLTI  = 7'd15,
		// Logic immediates, each with its own extension
		OP_ANDI  = 7'd8,
		OP_ORI   = 7'd9,
		OP_EORI  = 7'd10,
		OP_CSR   = 7'd7,
		// Floating point, where single prefixes hold single precision
		OP_FLT2  = 7'd18,
		OP_FLT3  = 7'd19,
		OP_JSR   = 7'd32,
		OP_RTD   = 7'd35,
		OP_FENCE = 7'd46,
		// Loads
		OP_LDB   = 7'd64,
		OP_LDBU  = 7'd65,
		OP_LDW   = 7'd66,
		OP_LDWU  = 7'd67,
		OP_LDT   = 7'd68,
		OP_LDTU  = 7'd69,
		OP_LDO   = 7'd70,
		OP_LDA   = 7'd74,
		OP_CACHE = 7'd76,
		// Stores
		OP_STB   = 7'd80,
		OP_STW   = 7'd81,
		OP_STT   = 7'd82,
		OP_STO   = 7'd83,
		// Immediate prefixes, legal only in this order behind a base
		OP_PFX   = 7'd120,
		OP_PFXA  = 7'd121,
		OP_PFXB  = 7'd122,
		OP_PFXC  = 7'd123,
		OP_NOP   = 7'd127
	} opcode_t;

	// Opcode in the low bits, everything else is decoded by field position
	typedef struct packed {
		logic [insWidth-opcodeWidth-1:0] body;
		opcode_t opcode;
	} instruction_t;

	// Empty window slots show this instruction
	localparam instruction_t nopIns = '{body: '0, opcode: OP_NOP};

	// ==============================
	// Field positions
	// ==============================

	// Base 16-bit immediate field, CSR uses a narrower top
	localparam int immHi = 34;
	localparam int immLo = 19;
	localparam int csrImmHi = 32;
	localparam int fenceImmHi = 23;
	localparam int fenceImmLo = 8;

	// Prefix payloads: PFX starts at bit 8, PFXA/B/C at bit 7
	localparam int pfxHi = 39;
	localparam int pfxLo = 8;
	localparam int pfxabcLo = 7;
	// Upper part taken from a second A, B or C prefix
	localparam int pfxExtHi = 37;

endpackage

// File: tb/tbImmModel.svh
/*
 * Reference model for instruction groups: group length and the base and
 * A/B/C immediates, worked out from the field rules on five entries
 */

`ifndef TB_IMM_MODEL_SVH
`define TB_IMM_MODEL_SVH

// Prefix opcode of kind k, in the only legal order
function automatic opcode_t kindOpcode(input int k);
	case (k)
	0: return OP_PFX;
	1: return OP_PFXA;
	2: return OP_PFXB;
	default: return OP_PFXC;
	endcase
endfunction

// First slot and count of the kind k prefixes behind the base
function automatic void findKind(input instruction_t g [5], input int k,
		output int at, output int cnt);
	int slot;
	int run;
	slot = 1;
	at = 1;
	cnt = 0;
	// A prefix in the base slot takes no prefixes of its own
	if (g[0].opcode inside {OP_PFX, OP_PFXA, OP_PFXB, OP_PFXC})
		return;
	for (int j = 0; j <= k; j++) begin
		run = 0;
		while (slot < 5 && run < 2 && g[slot].opcode == kindOpcode(j)) begin
			run++;
			slot++;
		end
		at = slot - run;
		cnt = run;
	end
endfunction

// Group length is where the last kind ends
function automatic int modelLen(input instruction_t g [5]);
	int at;
	int cnt;
	findKind(g, 3, at, cnt);
	return at + cnt;
endfunction

// The 16-bit field of the base, extended per opcode class
function automatic logic [63:0] baseField(input instruction_t ins);
	logic [15:0] f;
	f = ins[34:19];
	case (ins.opcode)
	OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI, OP_JSR,
	OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_CACHE,
	OP_STB, OP_STW, OP_STT, OP_STO:
		return 64'(signed'(f));
	OP_ANDI: return 64'hFFFF_FFFF_FFFF_0000 | 64'(f);
	OP_ORI, OP_EORI: return 64'(f);
	OP_CSR: return 64'(ins[32:19]);
	OP_RTD: return {32'd0, 32'(signed'(f))};
	OP_FENCE: return 64'(ins[23:8]);
	default: return 64'd0;
	endcase
endfunction

// IEEE single to double, with denormals flushed to a signed zero
function automatic logic [63:0] singleToDouble(input logic [31:0] s);
	logic [10:0] e;
	if (s[30:23] == 8'd0)
		return {s[31], 63'd0};
	if (s[30:23] == 8'hFF)
		e = 11'h7FF;
	else
		e = 11'(s[30:23]) - 11'd127 + 11'd1023;
	return {s[31], e, s[22:0], 29'd0};
endfunction

// Kind 0 is the base immediate, kinds 1 to 3 are A, B and C
function automatic logic [63:0] modelImm(input instruction_t g [5], input int k);
	int at;
	int cnt;
	logic [63:0] v;
	findKind(g, k, at, cnt);
	if (cnt == 0)
		return (k == 0) ? baseField(g[0]) : 64'd0;
	if (k == 0)
		v = 64'(signed'(g[at][39:8]));
	else
		v = 64'(signed'(g[at][39:7]));
	if (cnt == 2 && k == 0)
		v[63:32] = g[at+1][39:8];
	else if (cnt == 2)
		v[63:33] = g[at+1][37:7];
	if (cnt == 1 && g[0].opcode inside {OP_FLT2, OP_FLT3})
		v = singleToDouble(v[31:0]);
	return v;
endfunction

`endif

// File: tb/tbDecodeStage.sv
/*
 * Testbench for the decode stage. Directed and random instruction groups
 * feed a scoreboard through the reference model, assertions check outputs
 */

module tbDecodeStage import thorPkg::*; ();

	`include "tbImmModel.svh"

	localparam int queueDepth = 8;
	localparam int sbSize = 1024;
	localparam int waitLimit = 300;

	logic clk;
	logic rstN;
	logic push;
	instruction_t insIn;
	logic full;
	logic outReady;
	logic outValid;
	opcode_t outOpcode;
	logic [63:0] imm;
	logic [63:0] imma;
	logic [63:0] immb;
	logic [63:0] immc;
	logic [2:0] outLen;
	logic accepted;

	int seed = 73470;
	// Everything pushed so far, and where the next unscored group starts
	instruction_t stream [$];
	int parsePos = 0;
	// Scoreboard, filled at sbWr and consumed at sbRd
	opcode_t expOp [sbSize];
	int expLen [sbSize];
	logic [63:0] expImm [sbSize][4];
	int sbWr = 0;
	int sbRd = 0;

	opcode_t baseOps [30] = '{OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI,
		OP_ANDI, OP_ORI, OP_EORI, OP_CSR, OP_RTD, OP_JSR, OP_FENCE, OP_LDB, OP_LDBU,
		OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_CACHE, OP_STB, OP_STW,
		OP_STT, OP_STO, OP_FLT2, OP_FLT3, OP_NOP, OP_FLT3};

	decodeStage #(.queueDepth(queueDepth)) decodeStage_i (.*);

	assign accepted = outValid && outReady;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rstN)
			sbRd <= 0;
		else if (accepted)
			sbRd <= sbRd + 1;
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic valueError(input string name, input logic [63:0] expVal,
			input logic [63:0] gotVal);
		failRun($sformatf("error at %0t: %s expected %h got %h", $time, name, expVal, gotVal));
	endtask

	function automatic instruction_t randIns(input opcode_t op);
		instruction_t ins;
		ins = 40'({$random(seed), $random(seed)});
		ins.opcode = op;
		return ins;
	endfunction

	// Scores each group once the entry after it is known, or it fills the window
	task automatic scoreReady();
		instruction_t g [5];
		int len;
		bit done;
		done = 0;
		while (!done) begin
			for (int i = 0; i < 5; i++)
				g[i] = (parsePos + i < stream.size()) ? stream[parsePos + i] : nopIns;
			len = modelLen(g);
			if (len == 5 || parsePos + len < stream.size()) begin
				expOp[sbWr] = g[0].opcode;
				expLen[sbWr] = len;
				for (int k = 0; k < 4; k++)
					expImm[sbWr][k] = modelImm(g, k);
				sbWr++;
				parsePos += len;
			end else begin
				done = 1;
			end
		end
	endtask

	task automatic pushIns(input instruction_t ins);
		int waited;
		waited = 0;
		while (full && waited < waitLimit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (full) begin
			failRun("decoder stalled, the queue never drained");
		end else begin
			push = 1'b1;
			insIn = ins;
			stream.push_back(ins);
			scoreReady();
			@(posedge clk);
			#1;
			push = 1'b0;
		end
	endtask

	// Base followed by runs of PFX, PFXA, PFXB and PFXC in that order
	task automatic pushGroup(input opcode_t op, input int nP, nA, nB, nC);
		pushIns(randIns(op));
		repeat (nP) pushIns(randIns(OP_PFX));
		repeat (nA) pushIns(randIns(OP_PFXA));
		repeat (nB) pushIns(randIns(OP_PFXB));
		repeat (nC) pushIns(randIns(OP_PFXC));
	endtask

	// FP base with a lone prefix of every kind, each holding a single
	task automatic pushFpGroup(input opcode_t op, input logic [31:0] p, a, b, c);
		instruction_t ins;
		pushIns(randIns(op));
		ins = randIns(OP_PFX);
		ins[39:8] = p;
		pushIns(ins);
		ins = randIns(OP_PFXA);
		ins[38:7] = a;
		pushIns(ins);
		ins = randIns(OP_PFXB);
		ins[38:7] = b;
		pushIns(ins);
		ins = randIns(OP_PFXC);
		ins[38:7] = c;
		pushIns(ins);
	endtask

	// ==============================
	// Checks
	// ==============================

	noExtraOutput: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> sbRd < sbWr)
		else failRun("an output came out with no group left in the scoreboard");
	opcodeOk: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> outOpcode == expOp[sbRd])
		else valueError("outOpcode", 64'(expOp[$sampled(sbRd)]), 64'($sampled(outOpcode)));
	lenOk: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> int'(outLen) == expLen[sbRd])
		else valueError("outLen", 64'(expLen[$sampled(sbRd)]), 64'($sampled(outLen)));
	immOk: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> imm == expImm[sbRd][0])
		else valueError("imm", expImm[$sampled(sbRd)][0], $sampled(imm));
	immaOk: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> imma == expImm[sbRd][1])
		else valueError("imma", expImm[$sampled(sbRd)][1], $sampled(imma));
	immbOk: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> immb == expImm[sbRd][2])
		else valueError("immb", expImm[$sampled(sbRd)][2], $sampled(immb));
	immcOk: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> immc == expImm[sbRd][3])
		else valueError("immc", expImm[$sampled(sbRd)][3], $sampled(immc));
	// A stalled output holds every field
	stallHold: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> outValid && $stable(outOpcode) && $stable(imm)
			&& $stable(imma) && $stable(immb) && $stable(immc) && $stable(outLen))
		else failRun("outputs changed while outReady was low");

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		int waited;
		int n;
		rstN = 1'b0;
		push = 1'b0;
		insIn = nopIns;
		outReady = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		assert (!outValid && !full) else failRun("outValid or full high after reset");
		// A lone base is not complete until something follows it
		pushIns(randIns(OP_ADDI));
		repeat (3) @(posedge clk);
		#1;
		assert (!outValid) else failRun("outValid rose before a group was complete");

		// Every base opcode without prefixes
		for (int i = 0; i < 30; i++)
			pushIns(randIns(baseOps[i]));

		// One and two prefixes of each kind, then order breaks and overlong runs
		pushGroup(OP_ORI, 1, 0, 0, 0);
		pushGroup(OP_ORI, 2, 0, 0, 0);
		pushGroup(OP_LDO, 0, 1, 0, 0);
		pushGroup(OP_LDO, 0, 2, 0, 0);
		pushGroup(OP_SUBFI, 0, 0, 1, 0);
		pushGroup(OP_SUBFI, 0, 0, 2, 0);
		pushGroup(OP_JSR, 0, 0, 0, 1);
		pushGroup(OP_JSR, 0, 0, 0, 2);
		pushGroup(OP_STO, 2, 1, 0, 1);
		pushGroup(OP_ADDI, 0, 0, 1, 0);
		pushIns(randIns(OP_PFXA));
		pushIns(randIns(OP_PFX));
		pushGroup(OP_CMPI, 2, 2, 2, 0);
		pushGroup(OP_ANDI, 0, 3, 0, 0);

		// Zero, infinity, NaN, normals and denormals on both FP opcodes
		pushFpGroup(OP_FLT2, 32'h3F80_0000, 32'h0000_0000, 32'h8000_0000, 32'h7F80_0000);
		pushFpGroup(OP_FLT3, 32'hFF80_0000, 32'h7FC0_0001, 32'h0000_0001, 32'h8040_0000);
		pushFpGroup(OP_FLT2, 32'hC049_0FDB, 32'h7F7F_FFFF, 32'h0080_0000, 32'h3EAA_AAAB);

		// Back-pressure until the queue fills
		outReady = 1'b0;
		n = 0;
		while (!full && n < 4 * queueDepth) begin
			pushIns(randIns(baseOps[{$random(seed)} % 30]));
			n++;
		end
		repeat (4) @(posedge clk);
		#1;
		assert (full && outValid) else failRun("queue did not fill under back-pressure");
		outReady = 1'b1;

		// Random groups with now and then a stray prefix, streaming back to back
		for (int i = 0; i < 80; i++) begin
			if ({$random(seed)} % 6 == 0)
				pushIns(randIns(kindOpcode({$random(seed)} % 4)));
			else
				pushGroup(baseOps[{$random(seed)} % 30], {$random(seed)} % 3,
					{$random(seed)} % 3, {$random(seed)} % 3, {$random(seed)} % 3);
		end
		// Closes the last group, this entry itself is never scored
		pushIns(nopIns);

		waited = 0;
		while (sbRd != sbWr && waited < waitLimit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (sbRd == sbWr) begin
			$display("Test OK");
			$finish;
		end else begin
			failRun("decoder stalled with groups still waiting in the scoreboard");
		end
	end

endmodule
